// File: Makefile
VERILATOR ?= verilator
FILELIST  := core_slice_top.f
TOP_TB    := core_slice_tb
TOP_RTL   := core_slice_top
VFLAGS    := --timing --assert
OBJ_DIR   := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP_RTL)

sim:
	$(VERILATOR) --binary -j 0 $(VFLAGS) -f $(FILELIST) --top-module $(TOP_TB) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP_TB)

clean:
	rm -rf $(OBJ_DIR)

// File: core_slice_top.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/inst_rx.sv
hdl/idu_decoder.sv
hdl/gpr_file.sv
hdl/pipe_stage_reg.sv
hdl/exu_alu.sv
hdl/wb_tx.sv
hdl/hazard_ctrl.sv
hdl/core_slice_top.sv
tb/core_slice_tb.sv

// File: hdl/core_defines.svh
// core width macros
// address, data and register index widths
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

`define INST_ADDR_WIDTH 32   // instruction address bits
`define XLEN            32   // integer register and ALU width
`define REG_ADDR_WIDTH  5    // register index bits, 32 registers

`endif

// File: hdl/core_slice_top.sv
// integer pipeline slice top level
// receiver, decoder, register file, id/ex and ex/wb registers, ALU,
// result sender and hazard control
`timescale 1ns/1ps
`include "core_defines.svh"

module core_slice_top import pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  inst_pkt_t inst_i,
    input  logic      inst_req_i,
    output logic      inst_ack_o,
    output exu_res_t  result_o,
    output logic      result_req_o,
    input  logic      result_ack_i,
    input  logic      flush_i
);

    inst_pkt_t                  slot;
    logic                       slot_valid;
    logic [`REG_ADDR_WIDTH-1:0] rs1_addr;
    logic [`REG_ADDR_WIDTH-1:0] rs2_addr;
    logic [`XLEN-1:0]           rs1_data;
    logic [`XLEN-1:0]           rs2_data;
    dec_pkt_t                   dec;
    dec_pkt_t                   id_ex_q;
    exu_res_t                   alu_res;
    exu_res_t                   ex_wb_q;
    exu_res_t                   held;
    stage_ctrl_t                dec_ctrl;
    stage_ctrl_t                id_ex_ctrl;
    stage_ctrl_t                ex_wb_ctrl;
    logic                       wb_busy;
    logic                       gpr_we;
    logic [`REG_ADDR_WIDTH-1:0] gpr_waddr;
    logic [`XLEN-1:0]           gpr_wdata;

    inst_rx u_inst_rx (
        .clk(clk), .reset_i(reset_i), .inst_i(inst_i), .inst_req_i(inst_req_i),
        .inst_ack_o(inst_ack_o), .dec_ctrl_i(dec_ctrl), .slot_o(slot),
        .slot_valid_o(slot_valid)
    );

    idu_decoder u_idu_decoder (
        .slot_i(slot), .slot_valid_i(slot_valid), .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data), .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr), .dec_o(dec)
    );

    gpr_file u_gpr_file (
        .clk(clk), .reset_i(reset_i), .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .we_i(gpr_we),
        .waddr_i(gpr_waddr), .wdata_i(gpr_wdata)
    );

    pipe_stage_reg #(.payload_t(dec_pkt_t)) id_ex (
        .clk(clk), .reset_i(reset_i), .ctrl_i(id_ex_ctrl), .d_i(dec), .q_o(id_ex_q)
    );

    exu_alu u_exu_alu (
        .dec_i(id_ex_q), .res_o(alu_res)
    );

    pipe_stage_reg #(.payload_t(exu_res_t)) ex_wb (
        .clk(clk), .reset_i(reset_i), .ctrl_i(ex_wb_ctrl), .d_i(alu_res), .q_o(ex_wb_q)
    );

    wb_tx u_wb_tx (
        .clk(clk), .reset_i(reset_i), .res_i(ex_wb_q), .result_o(result_o),
        .result_req_o(result_req_o), .result_ack_i(result_ack_i), .busy_o(wb_busy),
        .held_o(held), .gpr_we_o(gpr_we), .gpr_waddr_o(gpr_waddr), .gpr_wdata_o(gpr_wdata)
    );

    hazard_ctrl u_hazard_ctrl (
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr), .dec_valid_i(slot_valid),
        .id_ex_i(id_ex_q), .ex_wb_i(ex_wb_q), .held_i(held), .wb_busy_i(wb_busy),
        .flush_i(flush_i), .dec_ctrl_o(dec_ctrl), .id_ex_ctrl_o(id_ex_ctrl),
        .ex_wb_ctrl_o(ex_wb_ctrl)
    );

endmodule

// File: hdl/exu_alu.sv
// integer ALU
// decode payload in, execute result out
`timescale 1ns/1ps
`include "core_defines.svh"

module exu_alu import isa_pkg::*, pipe_pkg::*; (
    input  dec_pkt_t dec_i,
    output exu_res_t res_o
);

    logic [`XLEN-1:0]         op_a;
    logic [`XLEN-1:0]         op_b;
    logic [$clog2(`XLEN)-1:0] shamt;
    logic [`XLEN-1:0]         result;

    assign op_a  = dec_i.rs1_val;
    assign op_b  = dec_i.use_imm ? dec_i.imm : dec_i.rs2_val;
    assign shamt = op_b[$clog2(`XLEN)-1:0];

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_SLL:  result = op_a << shamt;
            ALU_SLT:  result = `XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU: result = `XLEN'(op_a < op_b);
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SRL:  result = op_a >> shamt;
            ALU_SRA:  result = $signed(op_a) >>> shamt;
            ALU_OR:   result = op_a | op_b;
            ALU_AND:  result = op_a & op_b;
            ALU_PASS: result = op_b;        // lui
            default:  result = '0;
        endcase
    end

    assign res_o.valid     = dec_i.valid;
    assign res_o.illegal   = dec_i.illegal;
    assign res_o.inst_addr = dec_i.inst_addr;
    assign res_o.rd        = dec_i.rd;
    assign res_o.reg_we    = dec_i.reg_we;
    assign res_o.data      = dec_i.illegal ? '0 : result;

endmodule

// File: hdl/gpr_file.sv
// integer register file, 32 x 32 bit
// two async read ports, one write port, x0 reads as zero
`timescale 1ns/1ps
`include "core_defines.svh"

module gpr_file (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic [`REG_ADDR_WIDTH-1:0] rs1_addr_i,
    input  logic [`REG_ADDR_WIDTH-1:0] rs2_addr_i,
    output logic [`XLEN-1:0]           rs1_data_o,
    output logic [`XLEN-1:0]           rs2_data_o,
    input  logic                       we_i,
    input  logic [`REG_ADDR_WIDTH-1:0] waddr_i,
    input  logic [`XLEN-1:0]           wdata_i
);

    localparam int NUM_REGS = 2 ** `REG_ADDR_WIDTH;

    logic [`XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// File: hdl/hazard_ctrl.sv
// hazard control
// RAW scoreboard on decode, back-pressure from the result port, flush
`timescale 1ns/1ps
`include "core_defines.svh"

module hazard_ctrl import pipe_pkg::*; (
    input  logic [`REG_ADDR_WIDTH-1:0] rs1_addr_i,
    input  logic [`REG_ADDR_WIDTH-1:0] rs2_addr_i,
    input  logic                       dec_valid_i,
    input  dec_pkt_t                   id_ex_i,
    input  exu_res_t                   ex_wb_i,
    input  exu_res_t                   held_i,
    input  logic                       wb_busy_i,
    input  logic                       flush_i,
    output stage_ctrl_t                dec_ctrl_o,
    output stage_ctrl_t                id_ex_ctrl_o,
    output stage_ctrl_t                ex_wb_ctrl_o
);

    logic ex_wb_stall;
    logic raw_hazard;

    // an in-flight writer whose rd is read by the decode slot
    function automatic logic reads_rd(logic valid, logic we, logic [`REG_ADDR_WIDTH-1:0] rd);
        return valid && we && rd != '0 && (rd == rs1_addr_i || rd == rs2_addr_i);
    endfunction

    assign ex_wb_stall = ex_wb_i.valid && wb_busy_i;
    assign raw_hazard  = dec_valid_i &&
                         (reads_rd(id_ex_i.valid, id_ex_i.reg_we, id_ex_i.rd) ||
                          reads_rd(ex_wb_i.valid, ex_wb_i.reg_we, ex_wb_i.rd) ||
                          reads_rd(held_i.valid, held_i.reg_we, held_i.rd));

    assign ex_wb_ctrl_o = '{stall: ex_wb_stall, flush: flush_i};
    // a held decode slot sends a bubble when id_ex is free to move
    assign id_ex_ctrl_o = '{stall: ex_wb_stall, flush: flush_i || (raw_hazard && !ex_wb_stall)};
    assign dec_ctrl_o   = '{stall: ex_wb_stall || raw_hazard, flush: flush_i};

endmodule

// File: hdl/idu_decoder.sv
// RV32I subset decoder
// OP, OP-IMM and LUI into the decode payload, everything else illegal
`timescale 1ns/1ps
`include "core_defines.svh"

module idu_decoder import isa_pkg::*, pipe_pkg::*; (
    input  inst_pkt_t                  slot_i,
    input  logic                       slot_valid_i,
    input  logic [`XLEN-1:0]           rs1_data_i,
    input  logic [`XLEN-1:0]           rs2_data_i,
    output logic [`REG_ADDR_WIDTH-1:0] rs1_addr_o,
    output logic [`REG_ADDR_WIDTH-1:0] rs2_addr_o,
    output dec_pkt_t                   dec_o
);

    inst_fields_t fld;
    dec_pkt_t     dec;      // payload without operand values
    logic         alt;
    logic         base;

    function automatic alu_op_e f3_to_op(funct3_e f3, logic sub_sra);
        case (f3)
            F3_ADD_SUB: return sub_sra ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return sub_sra ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    assign fld  = slot_i.inst;
    assign alt  = (fld.funct7 == F7_ALT);
    assign base = (fld.funct7 == F7_BASE);

    always_comb begin
        dec           = '0;
        dec.valid     = slot_valid_i;
        dec.inst_addr = slot_i.inst_addr;
        dec.illegal   = slot_valid_i;   // cleared for the supported forms
        dec.alu_op    = ALU_ADD;
        if (slot_valid_i) begin
            case (fld.opcode)
                OPC_OP: begin
                    if (base || (alt && fld.funct3 inside {F3_ADD_SUB, F3_SRL_SRA})) begin
                        dec.illegal = 1'b0;
                        dec.alu_op  = f3_to_op(fld.funct3, alt);
                        dec.rs1     = fld.rs1;
                        dec.rs2     = fld.rs2;
                    end
                end
                OPC_OP_IMM: begin
                    // funct7 only matters for the shift forms
                    if (!(fld.funct3 inside {F3_SLL, F3_SRL_SRA}) || base ||
                        (alt && fld.funct3 == F3_SRL_SRA)) begin
                        dec.illegal = 1'b0;
                        dec.alu_op  = f3_to_op(fld.funct3, alt && fld.funct3 == F3_SRL_SRA);
                        dec.rs1     = fld.rs1;
                        dec.imm     = {{20{slot_i.inst[31]}}, slot_i.inst[31:20]};
                        dec.use_imm = 1'b1;
                    end
                end
                OPC_LUI: begin
                    dec.illegal = 1'b0;
                    dec.alu_op  = ALU_PASS;
                    dec.imm     = {slot_i.inst[31:12], 12'b0};
                    dec.use_imm = 1'b1;
                end
                default: ;
            endcase
        end
        dec.reg_we = dec.valid && !dec.illegal && (fld.rd != '0);
        dec.rd     = dec.reg_we ? fld.rd : '0;
    end

    assign rs1_addr_o = dec.rs1;
    assign rs2_addr_o = dec.rs2;

    always_comb begin
        dec_o         = dec;
        dec_o.rs1_val = rs1_data_i;
        dec_o.rs2_val = rs2_data_i;
    end

endmodule

// File: hdl/inst_rx.sv
// instruction receiver
// ack side of the four-phase port, holds the decode slot
`timescale 1ns/1ps

module inst_rx import pipe_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  inst_pkt_t   inst_i,
    input  logic        inst_req_i,
    output logic        inst_ack_o,
    input  stage_ctrl_t dec_ctrl_i,
    output inst_pkt_t   slot_o,
    output logic        slot_valid_o
);

    logic capture;

    assign capture = inst_req_i && !slot_valid_o && !inst_ack_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            slot_valid_o <= 1'b0;
            inst_ack_o   <= 1'b0;
        end else begin
            if (slot_valid_o && (dec_ctrl_i.flush || !dec_ctrl_i.stall)) begin
                slot_valid_o <= 1'b0;          // moved on or flushed
            end else if (capture) begin
                slot_valid_o <= 1'b1;
            end
            if (capture) begin
                inst_ack_o <= 1'b1;
            end else if (!inst_req_i) begin
                inst_ack_o <= 1'b0;            // source has dropped req
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            slot_o <= inst_i;
        end
    end

    a_ack_after_req: assert property (@(posedge clk) disable iff (reset_i)
        $rose(inst_ack_o) |-> $past(inst_req_i));

endmodule

// File: hdl/isa_pkg.sv
// RV32I encoding for the integer slice
// opcode, funct3 and ALU operation enums, funct7 codes, instruction fields
package isa_pkg;

    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // selects sub and sra

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_PASS  // lui, immediate straight through
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3_e    funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } inst_fields_t;

endpackage

// File: hdl/pipe_pkg.sv
// pipeline payloads of the integer slice
// fetch packet, decode payload, execute result, per-stage control
`include "core_defines.svh"

package pipe_pkg;
    import isa_pkg::*;

    typedef struct packed {
        logic [`INST_ADDR_WIDTH-1:0] inst_addr;
        inst_fields_t                inst;
    } inst_pkt_t;

    typedef struct packed {
        logic                        valid;
        logic                        illegal;
        logic [`INST_ADDR_WIDTH-1:0] inst_addr;
        logic [`REG_ADDR_WIDTH-1:0]  rd;
        logic                        reg_we;
        logic [`REG_ADDR_WIDTH-1:0]  rs1;
        logic [`REG_ADDR_WIDTH-1:0]  rs2;
        logic [`XLEN-1:0]            rs1_val;
        logic [`XLEN-1:0]            rs2_val;
        logic [`XLEN-1:0]            imm;
        logic                        use_imm;   // second operand is imm
        alu_op_e                     alu_op;
    } dec_pkt_t;

    // also the payload on the result port
    typedef struct packed {
        logic                        valid;
        logic                        illegal;
        logic [`INST_ADDR_WIDTH-1:0] inst_addr;
        logic [`REG_ADDR_WIDTH-1:0]  rd;
        logic                        reg_we;
        logic [`XLEN-1:0]            data;
    } exu_res_t;

    typedef struct packed {
        logic stall;
        logic flush;
    } stage_ctrl_t;

endpackage

// File: hdl/pipe_stage_reg.sv
// generic pipeline register
// holds on stall, loads an empty payload on flush
`timescale 1ns/1ps

module pipe_stage_reg import pipe_pkg::*; #(
    parameter type payload_t = logic [31:0]
) (
    input  logic        clk,
    input  logic        reset_i,
    input  stage_ctrl_t ctrl_i,
    input  payload_t    d_i,
    output payload_t    q_o
);

    always_ff @(posedge clk) begin
        if (reset_i || ctrl_i.flush) begin
            q_o <= '0;                  // flush wins over stall
        end else if (!ctrl_i.stall) begin
            q_o <= d_i;
        end
    end

    a_hold_on_stall: assert property (@(posedge clk) disable iff (reset_i)
        ctrl_i.stall && !ctrl_i.flush |=> $stable(q_o));

endmodule

// File: hdl/wb_tx.sv
// result sender
// req side of the four-phase result port, register-file write on ack
`timescale 1ns/1ps
`include "core_defines.svh"

module wb_tx import pipe_pkg::*; (
    input  logic                       clk,
    input  logic                       reset_i,
    input  exu_res_t                   res_i,
    output exu_res_t                   result_o,
    output logic                       result_req_o,
    input  logic                       result_ack_i,
    output logic                       busy_o,
    output exu_res_t                   held_o,
    output logic                       gpr_we_o,
    output logic [`REG_ADDR_WIDTH-1:0] gpr_waddr_o,
    output logic [`XLEN-1:0]           gpr_wdata_o
);

    exu_res_t held_q;
    logic     req_q;
    logic     wait_low_q;   // written back, waiting for ack to drop

    always_ff @(posedge clk) begin
        if (reset_i) begin
            req_q      <= 1'b0;
            wait_low_q <= 1'b0;
        end else if (req_q) begin
            if (result_ack_i) begin
                req_q      <= 1'b0;
                wait_low_q <= 1'b1;
            end
        end else if (wait_low_q) begin
            if (!result_ack_i) begin
                wait_low_q <= 1'b0;
            end
        end else if (res_i.valid) begin
            req_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy_o && res_i.valid) begin
            held_q <= res_i;
        end
    end

    assign busy_o       = req_q || wait_low_q;
    assign result_o     = held_q;
    assign result_req_o = req_q;

    // only a result not yet written counts for the scoreboard
    always_comb begin
        held_o       = held_q;
        held_o.valid = held_q.valid && req_q;
    end

    assign gpr_we_o    = req_q && result_ack_i && held_q.reg_we;
    assign gpr_waddr_o = held_q.rd;
    assign gpr_wdata_o = held_q.data;

    a_result_stable: assert property (@(posedge clk) disable iff (reset_i)
        result_req_o |=> !result_req_o || $stable(result_o));

endmodule

// File: tb/core_slice_tb.sv
// testbench for the integer pipeline slice
// LFSR program, four-phase source and sink, reference register model,
// checking assertions and watchdog
`timescale 1ns/1ps
`include "core_defines.svh"

module core_slice_tb import pipe_pkg::*; ();

    localparam int          N_INST    = 256;
    localparam logic [31:0] BASE_ADDR = 32'h0000_1000;
    localparam logic [31:0] SEED      = 32'h2a99_0c9c;

    logic        clk;
    logic        reset_i;
    inst_pkt_t   inst_i;
    logic        inst_req_i;
    logic        inst_ack_o;
    exu_res_t    result_o;
    logic        result_req_o;
    logic        result_ack_i;
    logic        flush_i;

    logic [31:0]      lfsr_state;
    logic [31:0]      prog [N_INST];       // instruction word per address slot
    logic [1:0]       ack_delay [N_INST];
    logic [`XLEN-1:0] model [32];          // reference registers
    logic [31:0]      next_addr;
    logic [31:0]      last_addr;           // address of the last written result
    logic             req_seen;
    logic [31:0]      flush_addr;          // first address sent after the last flush
    int               flush_count;
    int               result_count;
    exu_res_t         exp_res;
    logic [31:0]      exp_off;
    logic [31:0]      exp_word;

    core_slice_top DUT (
        .clk(clk), .reset_i(reset_i), .inst_i(inst_i), .inst_req_i(inst_req_i),
        .inst_ack_o(inst_ack_o), .result_o(result_o), .result_req_o(result_req_o),
        .result_ack_i(result_ack_i), .flush_i(flush_i)
    );

    task automatic halt_run;
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(input string what);
        $display("at %0t: %s", $time, what);
        halt_run();
    endtask

    task automatic report_mismatch(input string sig, input exu_res_t exp_v, input exu_res_t got_v);
        $display("ERROR at %0t: %s expected %h got %h", $time, sig, exp_v, got_v);
        halt_run();
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // RV32I subset membership
    function automatic logic is_legal(input logic [31:0] w);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = w[31:25];
        f3 = w[14:12];
        case (w[6:0])
            7'b0110011: return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            7'b0010011: begin
                if (f3 == 3'd1) begin
                    return f7 == 7'h00;
                end else if (f3 == 3'd5) begin
                    return f7 == 7'h00 || f7 == 7'h20;
                end else begin
                    return 1'b1;
                end
            end
            7'b0110111: return 1'b1;
            default:    return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] rv_result(input logic [31:0] w, input logic [31:0] a,
                                              input logic [31:0] rs2v);
        logic [31:0] b;
        logic [4:0]  sh;
        if (w[6:0] == 7'b0110111) begin
            return {w[31:12], 12'h000};          // lui
        end
        b  = (w[6:0] == 7'b0010011) ? {{20{w[31]}}, w[31:20]} : rs2v;
        sh = b[4:0];
        case (w[14:12])
            3'd0: return (w[6:0] == 7'b0110011 && w[30]) ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (w[30]) begin
                    return $signed(a) >>> sh;
                end else begin
                    return a >> sh;
                end
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic build_program;
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  prev_rd;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [6:0]  opc;
        prev_rd = 5'd1;
        for (int i = 0; i < N_INST; i++) begin
            r   = rand_bits(3);
            rd  = {2'b00, r[2:0]};                       // x0 now and then
            r   = rand_bits(4);
            rs1 = r[3] ? prev_rd : {2'b00, r[2:0]};      // dependent chain
            r   = rand_bits(3);
            rs2 = {2'b00, r[2:0]};
            r   = rand_bits(3);
            f3  = r[2:0];
            r   = rand_bits(2);
            case (r[1:0])
                2'd0: begin
                    r = rand_bits(1);
                    prog[i[7:0]] = {r[0] ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'b0110011};
                end
                2'd1: begin
                    r   = rand_bits(12);
                    imm = r[11:0];
                    if (f3 == 3'd1 || f3 == 3'd5) begin
                        imm[11:5] = imm[11] ? 7'h20 : 7'h00;   // shift forms
                    end
                    prog[i[7:0]] = {imm, rs1, f3, rd, 7'b0010011};
                end
                2'd2: begin
                    r = rand_bits(20);
                    prog[i[7:0]] = {r[19:0], rd, 7'b0110111};
                end
                default: begin
                    r   = rand_bits(30);
                    opc = {r[4:0], 2'b11};
                    if (opc == 7'b0110011 || opc == 7'b0010011 || opc == 7'b0110111) begin
                        opc = 7'b0000011;                // load, outside the subset
                    end
                    prog[i[7:0]] = {r[29:5], opc};
                end
            endcase
            prev_rd = rd;
            r = rand_bits(2);
            ack_delay[i[7:0]] = r[1:0];
        end
    endtask

    task automatic send_inst(input logic [31:0] word);
        inst_i     = {next_addr, word};
        inst_req_i = 1'b1;
        req_seen   = 1'b1;
        next_addr  = next_addr + 32'd4;
        do @(negedge clk); while (!inst_ack_o);
        inst_req_i = 1'b0;
        do @(negedge clk); while (inst_ack_o);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // expected result for the instruction now on result_o
    always_comb begin
        exp_off           = result_o.inst_addr - BASE_ADDR;
        exp_word          = prog[exp_off[9:2]];
        exp_res           = '0;
        exp_res.valid     = 1'b1;
        exp_res.inst_addr = result_o.inst_addr;
        exp_res.illegal   = !is_legal(exp_word);
        exp_res.reg_we    = !exp_res.illegal && exp_word[11:7] != 5'd0;
        exp_res.rd        = exp_res.reg_we ? exp_word[11:7] : 5'd0;
        exp_res.data      = exp_res.illegal ? '0 :
                            rv_result(exp_word, model[exp_word[19:15]], model[exp_word[24:20]]);
    end

    always @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                model[i[4:0]] <= '0;
            end
            last_addr    <= BASE_ADDR - 32'd4;
            result_count <= 0;
        end else if (result_req_o && result_ack_i) begin
            if (exp_res.reg_we) begin
                model[exp_res.rd] <= exp_res.data;   // same edge as the DUT write
            end
            last_addr    <= result_o.inst_addr;
            result_count <= result_count + 1;
        end
    end

    a_result_value: assert property (@(posedge clk) disable iff (reset_i)
        result_req_o |-> result_o == exp_res)
        else report_mismatch("result_o", $sampled(exp_res), $sampled(result_o));

    // a gap in the addresses only covers instructions in flight at the last flush
    a_result_order: assert property (@(posedge clk) disable iff (reset_i)
        $rose(result_req_o) |-> result_o.inst_addr > last_addr &&
            result_o.inst_addr < next_addr && result_o.inst_addr[1:0] == 2'b00 &&
            (result_o.inst_addr <= flush_addr || result_o.inst_addr == last_addr + 32'd4))
        else report_failure($sformatf("result address %h out of order after %h",
                                      $sampled(result_o.inst_addr), $sampled(last_addr)));

    a_result_hold: assert property (@(posedge clk) disable iff (reset_i)
        result_req_o && !result_ack_i |=> result_req_o && $stable(result_o))
        else report_failure("result_req_o dropped or result_o changed before ack");

    a_result_ack_low: assert property (@(posedge clk) disable iff (reset_i)
        result_ack_i |=> !result_req_o)
        else report_failure("result_req_o high while result_ack_i was high");

    a_inst_ack_rise: assert property (@(posedge clk) disable iff (reset_i)
        !inst_req_i |=> !inst_ack_o)
        else report_failure("inst_ack_o high after inst_req_i was low");

    a_inst_ack_hold: assert property (@(posedge clk) disable iff (reset_i)
        inst_ack_o && inst_req_i |=> inst_ack_o)
        else report_failure("inst_ack_o dropped while inst_req_i was high");

    a_idle_after_reset: assert property (@(posedge clk) disable iff (reset_i)
        !req_seen |-> !inst_ack_o && !result_req_o)
        else report_failure("handshake output high before the first request");

    // result sink with LFSR ack delays
    initial begin
        logic [7:0] n;
        result_ack_i = 1'b0;
        n = '0;
        forever begin
            do @(negedge clk); while (!result_req_o);
            repeat (ack_delay[n]) @(negedge clk);
            result_ack_i = 1'b1;
            do @(negedge clk); while (result_req_o);
            result_ack_i = 1'b0;
            n = n + 8'd1;
        end
    end

    initial begin
        repeat (200 * N_INST) @(posedge clk);
        report_failure("watchdog expired before the last result came out");
    end

    initial begin
        reset_i     = 1'b1;
        inst_i      = '0;
        inst_req_i  = 1'b0;
        flush_i     = 1'b0;
        req_seen    = 1'b0;
        flush_addr  = BASE_ADDR;
        flush_count = 0;
        next_addr   = BASE_ADDR;
        lfsr_state  = SEED;
        build_program();
        repeat (5) @(negedge clk);
        reset_i = 1'b0;
        repeat (3) @(negedge clk);                       // idle port check
        for (int i = 0; i < N_INST; i++) begin
            send_inst(prog[i[7:0]]);
            // flushes in the second half only, tail left clean
            if (i >= N_INST / 2 && i < N_INST - 16 && i % 16 == 5) begin
                flush_i     = 1'b1;
                flush_addr  = next_addr;
                flush_count = flush_count + 1;
                @(negedge clk);
                flush_i = 1'b0;
            end
        end
        while (last_addr != next_addr - 32'd4) @(negedge clk);
        // each flush drops the instruction just sent, and at most two more
        if (result_count <= N_INST - flush_count &&
            result_count >= N_INST - 3 * flush_count) begin
            $display("Everything OK");
            $finish;
        end else begin
            report_failure("result count does not fit the number of flushes");
        end
    end

endmodule
